// File: Makefile
RTL = logic/cgra_pkg.sv logic/connect_box.sv logic/switch_box.sv logic/pe_core.sv \
      logic/pe_tile.sv logic/cgra_array.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module cgra_array $(RTL)

sim:
	verilator --binary --timing --top-module cgra_tb -f all.f -o cgra_sim
	out=$$(./obj_dir/cgra_sim); echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: all.f
logic/cgra_pkg.sv
logic/connect_box.sv
logic/switch_box.sv
logic/pe_core.sv
logic/pe_tile.sv
logic/cgra_array.sv
bench/cgra_tb.sv

// File: bench/cgra_tb.sv
`timescale 1ns/1ps

module cgra_tb;

   import cgra_pkg::*;

   logic              clk;
   logic              reset;
   logic [31:0]       config_addr;
   logic [31:0]       config_data;
   logic [TRACKS-1:0] west_in;
   logic [TRACKS-1:0] north0_in;
   logic [TRACKS-1:0] south0_in;
   logic [TRACKS-1:0] north1_in;
   logic [TRACKS-1:0] south1_in;
   logic [TRACKS-1:0] east_in;
   logic [TRACKS-1:0] west_out;
   logic [TRACKS-1:0] north0_out;
   logic [TRACKS-1:0] south0_out;
   logic [TRACKS-1:0] north1_out;
   logic [TRACKS-1:0] south1_out;
   logic [TRACKS-1:0] east_out;

   logic [31:0] cfg_route [2];  // copies of the written config.
   logic [1:0]  cfg_cb0   [2];
   logic [1:0]  cfg_cb1   [2];
   pe_op_e      cfg_op    [2];
   logic        exp_pe    [2];  // modelled pe_out per tile.
   logic        checking;

   cgra_array UUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin : release_reset
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
   end

   function automatic logic ref_pe(input pe_op_e op, input logic a, input logic b);
      case (op)
         op_and:    return a & b;
         op_or:     return a | b;
         op_xor:    return a ^ b;
         op_nand:   return ~(a & b);
         op_nor:    return ~(a | b);
         op_xnor:   return ~(a ^ b);
         op_pass_a: return a;
         op_not_a:  return ~a;
         default:   return 1'b0;
      endcase
   endfunction

   // ins holds the four incoming sides, side 0 in the low bits.
   function automatic logic [TRACKS-1:0] ref_route(input logic [31:0] word, input int side,
                                                   input logic [4*TRACKS-1:0] ins,
                                                   input logic pe);
      logic [TRACKS-1:0] res;
      sb_src_e           src;
      int                from;
      for (int t = 0; t < TRACKS; t++) begin
         src = sb_src_e'(word[2*(TRACKS*side+t) +: 2]);
         from = (side + int'(src)) % SIDES;
         res[t] = (src == src_pe) ? pe : ins[TRACKS*from+t];
      end
      return res;
   endfunction

   function automatic logic track_of(input logic [4*TRACKS-1:0] ins, input int side,
                                     input logic [1:0] sel);
      return ins[TRACKS*side+int'(sel)];
   endfunction

   function automatic logic [31:0] address_of(input logic [15:0] feature,
                                              input logic [15:0] tile);
      return {feature, tile};
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_vec(input string name, input logic [TRACKS-1:0] expected,
                            input logic [TRACKS-1:0] actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                                     $time, name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %b, got %b",
                                     $time, name, expected, actual));
      end
   endtask

   task automatic check_all_zero();
      check_vec("west_out", '0, west_out);
      check_vec("north0_out", '0, north0_out);
      check_vec("south0_out", '0, south0_out);
      check_vec("north1_out", '0, north1_out);
      check_vec("south1_out", '0, south1_out);
      check_vec("east_out", '0, east_out);
   endtask

   task automatic wait_reset_done();
      int cycles;
      cycles = 0;
      while (reset) begin
         @(negedge clk);
         cycles++;
         if (cycles > 10) begin
            stop_with_failure("timeout: reset still high after 10 cycles");
         end
      end
   endtask

   task automatic hold_reset();
      @(posedge clk);
      #1;
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
   endtask

   task automatic write_config(input logic [31:0] addr, input logic [31:0] data);
      logic [15:0] tile_field;
      tile_field = addr[15:0];
      @(posedge clk);
      #1;
      config_addr = addr;
      config_data = data;
      @(posedge clk);
      #1;
      if (tile_field < 16'd2) begin
         case (addr[31:16])
            FEAT_CB0: cfg_cb0[tile_field[0]] = data[1:0];
            FEAT_CB1: cfg_cb1[tile_field[0]] = data[1:0];
            FEAT_SB:  cfg_route[tile_field[0]] = data;
            FEAT_PE:  cfg_op[tile_field[0]] = pe_op_e'(data[2:0]);
            default:  ;
         endcase
      end
      config_addr = address_of(16'd0, 16'd0);  // feature 0, matches nothing.
      config_data = '0;
   endtask

   task automatic drive_random_inputs();
      west_in   = 4'($urandom);
      north0_in = 4'($urandom);
      south0_in = 4'($urandom);
      north1_in = 4'($urandom);
      south1_in = 4'($urandom);
      east_in   = 4'($urandom);
   endtask

   initial begin : compare
      logic [4*TRACKS-1:0] ins0;
      logic [4*TRACKS-1:0] ins1;
      logic [TRACKS-1:0]   link01;
      logic [TRACKS-1:0]   link10;
      forever begin
         @(posedge clk);
         #9;
         // tile 0 east never reads its own east input.
         link01 = ref_route(cfg_route[0], 2, {south0_in, 4'h0, north0_in, west_in}, exp_pe[0]);
         ins1 = {south1_in, east_in, north1_in, link01};
         link10 = ref_route(cfg_route[1], 0, ins1, exp_pe[1]);
         ins0 = {south0_in, link10, north0_in, west_in};
         if (checking) begin
            check_vec("west_out", ref_route(cfg_route[0], 0, ins0, exp_pe[0]), west_out);
            check_vec("north0_out", ref_route(cfg_route[0], 1, ins0, exp_pe[0]), north0_out);
            check_vec("south0_out", ref_route(cfg_route[0], 3, ins0, exp_pe[0]), south0_out);
            check_vec("north1_out", ref_route(cfg_route[1], 1, ins1, exp_pe[1]), north1_out);
            check_vec("south1_out", ref_route(cfg_route[1], 3, ins1, exp_pe[1]), south1_out);
            check_vec("east_out", ref_route(cfg_route[1], 2, ins1, exp_pe[1]), east_out);
         end
         if (reset) begin
            for (int i = 0; i < 2; i++) begin
               cfg_route[i] = '0;
               cfg_cb0[i]   = '0;
               cfg_cb1[i]   = '0;
               cfg_op[i]    = op_and;
               exp_pe[i]    = 1'b0;
            end
         end else begin
            exp_pe[0] = ref_pe(cfg_op[0], track_of(ins0, 0, cfg_cb0[0]),
                               track_of(ins0, 1, cfg_cb1[0]));
            exp_pe[1] = ref_pe(cfg_op[1], track_of(ins1, 0, cfg_cb0[1]),
                               track_of(ins1, 1, cfg_cb1[1]));
         end
      end
   end

   initial begin : main
      pe_op_e     op;
      logic [1:0] sel0;
      logic [1:0] sel1;
      logic       prev;
      logic       have_prev;
      void'($urandom(54));
      reset       = 1'b1;
      checking    = 1'b0;
      config_addr = '0;
      config_data = '0;
      west_in     = '0;
      north0_in   = '0;
      south0_in   = '0;
      north1_in   = '0;
      south1_in   = '0;
      east_in     = '0;
      wait_reset_done();
      @(posedge clk);
      #4;
      check_all_zero();
      checking = 1'b1;

      // west straight through to east.
      write_config(address_of(FEAT_SB, 16'd0), 32'h00AA_0000);
      write_config(address_of(FEAT_SB, 16'd1), 32'h00AA_0000);
      repeat (12) begin
         @(posedge clk);
         #1;
         drive_random_inputs();
         #4;
         check_vec("east_out", west_in, east_out);
      end

      // tile 1 north tracks all carry pe_out.
      write_config(address_of(FEAT_SB, 16'd1), 32'h0000_0000);
      for (int k = 0; k < 8; k++) begin
         op   = pe_op_e'(k);
         sel0 = 2'($urandom);
         sel1 = 2'($urandom);
         write_config(address_of(FEAT_CB0, 16'd1), {30'd0, sel0});
         write_config(address_of(FEAT_CB1, 16'd1), {30'd0, sel1});
         write_config(address_of(FEAT_PE, 16'd1), {29'd0, op});
         have_prev = 1'b0;
         repeat (8) begin
            @(posedge clk);
            #1;
            west_in   = 4'($urandom);
            north1_in = 4'($urandom);
            #4;
            if (have_prev) begin
               check_bit("north1_out[0]", prev, north1_out[0]);
            end
            prev      = ref_pe(op, west_in[sel0], north1_in[sel1]);
            have_prev = 1'b1;
         end
      end

      // random config on both tiles.
      repeat (6) begin
         for (int i = 0; i < 2; i++) begin
            write_config(address_of(FEAT_SB, 16'(i)), $urandom);
            write_config(address_of(FEAT_CB0, 16'(i)), $urandom);
            write_config(address_of(FEAT_CB1, 16'(i)), $urandom);
            write_config(address_of(FEAT_PE, 16'(i)), $urandom);
         end
         repeat (20) begin
            @(posedge clk);
            #1;
            drive_random_inputs();
         end
      end

      // writes that hit no tile or no feature.
      write_config(address_of(FEAT_SB, 16'd2), $urandom);
      for (int f = 0; f < 4; f++) begin
         write_config(address_of(16'(f), 16'd0), $urandom);
      end
      write_config(address_of(16'd8, 16'd1), $urandom);
      repeat (10) begin
         @(posedge clk);
         #1;
         drive_random_inputs();
      end

      hold_reset();
      wait_reset_done();
      #4;
      check_all_zero();
      repeat (2) @(posedge clk);
      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: logic/cgra_array.sv
`timescale 1ns/1ps

module cgra_array (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [31:0]                 config_addr,
   input  logic [31:0]                 config_data,
   input  logic [cgra_pkg::TRACKS-1:0] west_in,
   input  logic [cgra_pkg::TRACKS-1:0] north0_in,
   input  logic [cgra_pkg::TRACKS-1:0] south0_in,
   input  logic [cgra_pkg::TRACKS-1:0] north1_in,
   input  logic [cgra_pkg::TRACKS-1:0] south1_in,
   input  logic [cgra_pkg::TRACKS-1:0] east_in,
   output logic [cgra_pkg::TRACKS-1:0] west_out,
   output logic [cgra_pkg::TRACKS-1:0] north0_out,
   output logic [cgra_pkg::TRACKS-1:0] south0_out,
   output logic [cgra_pkg::TRACKS-1:0] north1_out,
   output logic [cgra_pkg::TRACKS-1:0] south1_out,
   output logic [cgra_pkg::TRACKS-1:0] east_out
);

   import cgra_pkg::*;

   logic [TRACKS-1:0] t0_to_t1;  // tile 0 east into tile 1 west.
   logic [TRACKS-1:0] t1_to_t0;  // tile 1 west into tile 0 east.

   pe_tile #(
      .TILE_ID (16'd0)
   ) tile0 (
      .clk         (clk),
      .reset       (reset),
      .config_addr (config_addr),
      .config_data (config_data),
      .side0_in    (west_in),
      .side1_in    (north0_in),
      .side2_in    (t1_to_t0),
      .side3_in    (south0_in),
      .side0_out   (west_out),
      .side1_out   (north0_out),
      .side2_out   (t0_to_t1),
      .side3_out   (south0_out)
   );

   pe_tile #(
      .TILE_ID (16'd1)
   ) tile1 (
      .clk         (clk),
      .reset       (reset),
      .config_addr (config_addr),
      .config_data (config_data),
      .side0_in    (t0_to_t1),
      .side1_in    (north1_in),
      .side2_in    (east_in),
      .side3_in    (south1_in),
      .side0_out   (t1_to_t0),
      .side1_out   (north1_out),
      .side2_out   (east_out),
      .side3_out   (south1_out)
   );

endmodule

// File: logic/cgra_pkg.sv
package cgra_pkg;

   localparam int TRACKS = 4;  // tracks per side.
   localparam int SIDES  = 4;  // west, north, east, south.

   localparam int ROUTE_BITS = 2 * TRACKS * SIDES;  // switch box word.

   // feature codes in config_addr[31:16].
   localparam logic [15:0] FEAT_CB0 = 16'd4;
   localparam logic [15:0] FEAT_CB1 = 16'd5;
   localparam logic [15:0] FEAT_SB  = 16'd6;
   localparam logic [15:0] FEAT_PE  = 16'd7;

   typedef logic [15:0] tile_id_t;

   typedef enum logic [2:0] {
      op_and    = 3'd0,
      op_or     = 3'd1,
      op_xor    = 3'd2,
      op_nand   = 3'd3,
      op_nor    = 3'd4,
      op_xnor   = 3'd5,
      op_pass_a = 3'd6,
      op_not_a  = 3'd7
   } pe_op_e;

   // source of an outgoing track, relative to its own side.
   typedef enum logic [1:0] {
      src_pe     = 2'd0,
      src_side_1 = 2'd1,
      src_side_2 = 2'd2,
      src_side_3 = 2'd3
   } sb_src_e;

endpackage

// File: logic/connect_box.sv
`timescale 1ns/1ps

module connect_box (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        config_en,
   input  logic [31:0]                 config_data,
   input  logic [cgra_pkg::TRACKS-1:0] tracks_in,
   output logic                        operand
);

   import cgra_pkg::*;

   localparam int SEL_W = $clog2(TRACKS);

   logic [SEL_W-1:0] track_sel;  // picked track.

   always_ff @(posedge clk) begin
      if (reset) begin
         track_sel <= '0;
      end else if (config_en) begin
         track_sel <= config_data[SEL_W-1:0];
      end
   end

   // combinational select from the tracks.
   assign operand = tracks_in[track_sel];

endmodule

// File: logic/pe_core.sv
`timescale 1ns/1ps

module pe_core (
   input  logic        clk,
   input  logic        reset,
   input  logic        config_en,
   input  logic [31:0] config_data,
   input  logic        operand0,
   input  logic        operand1,
   output logic        pe_out
);

   import cgra_pkg::*;

   pe_op_e op;      // configured operation.
   logic   result;

   always_ff @(posedge clk) begin
      if (reset) begin
         op <= op_and;
      end else if (config_en) begin
         op <= pe_op_e'(config_data[2:0]);
      end
   end

   always_comb begin
      case (op)
         op_and:    result = operand0 & operand1;
         op_or:     result = operand0 | operand1;
         op_xor:    result = operand0 ^ operand1;
         op_nand:   result = ~(operand0 & operand1);
         op_nor:    result = ~(operand0 | operand1);
         op_xnor:   result = ~(operand0 ^ operand1);
         op_pass_a: result = operand0;
         op_not_a:  result = ~operand0;
         default:   result = 1'b0;
      endcase
   end

   // one cycle of latency from operands to pe_out.
   always_ff @(posedge clk) begin
      if (reset) begin
         pe_out <= 1'b0;
      end else begin
         pe_out <= result;
      end
   end

endmodule

// File: logic/pe_tile.sv
`timescale 1ns/1ps

module pe_tile #(
   parameter cgra_pkg::tile_id_t TILE_ID = '0
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [31:0]                 config_addr,
   input  logic [31:0]                 config_data,
   input  logic [cgra_pkg::TRACKS-1:0] side0_in,
   input  logic [cgra_pkg::TRACKS-1:0] side1_in,
   input  logic [cgra_pkg::TRACKS-1:0] side2_in,
   input  logic [cgra_pkg::TRACKS-1:0] side3_in,
   output logic [cgra_pkg::TRACKS-1:0] side0_out,
   output logic [cgra_pkg::TRACKS-1:0] side1_out,
   output logic [cgra_pkg::TRACKS-1:0] side2_out,
   output logic [cgra_pkg::TRACKS-1:0] side3_out
);

   import cgra_pkg::*;

   logic        this_tile;
   logic [15:0] feature;
   logic        config_en_cb0;
   logic        config_en_cb1;
   logic        config_en_sb;
   logic        config_en_pe;

   logic operand0;
   logic operand1;
   logic pe_out;

   assign this_tile = (config_addr[15:0] == TILE_ID);
   assign feature   = config_addr[31:16];

   // at most one enable per tile.
   assign config_en_cb0 = this_tile && (feature == FEAT_CB0);
   assign config_en_cb1 = this_tile && (feature == FEAT_CB1);
   assign config_en_sb  = this_tile && (feature == FEAT_SB);
   assign config_en_pe  = this_tile && (feature == FEAT_PE);

   connect_box cb0 (
      .clk         (clk),
      .reset       (reset),
      .config_en   (config_en_cb0),
      .config_data (config_data),
      .tracks_in   (side0_in),   // west side.
      .operand     (operand0)
   );

   connect_box cb1 (
      .clk         (clk),
      .reset       (reset),
      .config_en   (config_en_cb1),
      .config_data (config_data),
      .tracks_in   (side1_in),   // north side.
      .operand     (operand1)
   );

   pe_core pe (
      .clk         (clk),
      .reset       (reset),
      .config_en   (config_en_pe),
      .config_data (config_data),
      .operand0    (operand0),
      .operand1    (operand1),
      .pe_out      (pe_out)
   );

   switch_box sb (
      .clk         (clk),
      .reset       (reset),
      .config_en   (config_en_sb),
      .config_data (config_data),
      .side0_in    (side0_in),
      .side1_in    (side1_in),
      .side2_in    (side2_in),
      .side3_in    (side3_in),
      .pe_out      (pe_out),
      .side0_out   (side0_out),
      .side1_out   (side1_out),
      .side2_out   (side2_out),
      .side3_out   (side3_out)
   );

endmodule

// File: logic/switch_box.sv
`timescale 1ns/1ps

module switch_box (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        config_en,
   input  logic [31:0]                 config_data,
   input  logic [cgra_pkg::TRACKS-1:0] side0_in,
   input  logic [cgra_pkg::TRACKS-1:0] side1_in,
   input  logic [cgra_pkg::TRACKS-1:0] side2_in,
   input  logic [cgra_pkg::TRACKS-1:0] side3_in,
   input  logic                        pe_out,
   output logic [cgra_pkg::TRACKS-1:0] side0_out,
   output logic [cgra_pkg::TRACKS-1:0] side1_out,
   output logic [cgra_pkg::TRACKS-1:0] side2_out,
   output logic [cgra_pkg::TRACKS-1:0] side3_out
);

   import cgra_pkg::*;

   logic [ROUTE_BITS-1:0] route_cfg;  // 2 bits per outgoing track.

   always_ff @(posedge clk) begin
      if (reset) begin
         route_cfg <= '0;
      end else if (config_en) begin
         route_cfg <= config_data[ROUTE_BITS-1:0];
      end
   end

   // one outgoing side from its own fields and the other three sides.
   function automatic logic [TRACKS-1:0] route_side(input logic [2*TRACKS-1:0] fields,
                                                    input logic [TRACKS-1:0]   near,
                                                    input logic [TRACKS-1:0]   opposite,
                                                    input logic [TRACKS-1:0]   far,
                                                    input logic                pe);
      logic [TRACKS-1:0] res;
      sb_src_e           src;
      for (int t = 0; t < TRACKS; t++) begin
         src = sb_src_e'(fields[2*t +: 2]);
         case (src)
            src_pe:     res[t] = pe;
            src_side_1: res[t] = near[t];
            src_side_2: res[t] = opposite[t];
            src_side_3: res[t] = far[t];
            default:    res[t] = pe;
         endcase
      end
      return res;
   endfunction

   // field for side s, track t sits at 2*(4s+t).
   assign side0_out = route_side(route_cfg[0 +: 2*TRACKS], side1_in, side2_in, side3_in,
                                 pe_out);
   assign side1_out = route_side(route_cfg[2*TRACKS +: 2*TRACKS], side2_in, side3_in,
                                 side0_in, pe_out);
   assign side2_out = route_side(route_cfg[4*TRACKS +: 2*TRACKS], side3_in, side0_in,
                                 side1_in, pe_out);
   assign side3_out = route_side(route_cfg[6*TRACKS +: 2*TRACKS], side0_in, side1_in,
                                 side2_in, pe_out);

endmodule
